/* hw/regf_pkg.sv */
`default_nettype none

// ----------------------------------------
// Register file geometry
// ----------------------------------------

package regf_pkg;

        // Address bits, enough for 64 registers
        localparam int REGF_ADDR_W = 6;

        // One architectural register
        localparam int REGF_DATA_W = 32;

        // Registers actually present
        localparam int REGF_DEPTH  = 64;

        // ----------------------------------------
        // Typed vectors
        // ----------------------------------------

        // Register index
        typedef logic [REGF_ADDR_W-1:0] regf_addr_t;

        // Register contents
        typedef logic [REGF_DATA_W-1:0] regf_data_t;

endpackage : regf_pkg

`default_nettype wire

/* hw/pump_pkg.sv */
`default_nettype none

// ----------------------------------------
// Multipump sequencing
// ----------------------------------------

package pump_pkg;

        // Two pump cycles per core cycle
        // Read phase first, then write phase
        typedef enum logic [0:0] {
                READ_PH  = 1'b0,
                WRITE_PH = 1'b1
        } pump_phase_t;

        // One RAM copy per core read port
        localparam int PUMP_READ_BANKS = 4;

endpackage : pump_pkg

`default_nettype wire

/* hw/regf_block_ram.sv */
`timescale 1ns/1ps
`default_nettype none

// Single RAM bank of the register file
// Two write addresses share one write enable
// Read port shares address a

module regf_block_ram
        import regf_pkg::*;
#(
        parameter int P_DEPTH = REGF_DEPTH
)
(
        input  wire             i_clk_multipump,

        // Address a doubles as the read address
        input  regf_addr_t      i_addr_a,
        input  regf_addr_t      i_addr_b,

        input  wire             i_wen,

        input  regf_data_t      i_wr_data_a,
        input  regf_data_t      i_wr_data_b,

        // Registered read word
        output regf_data_t      o_rd_data_a
);

// ----------------------------------------
// Storage
// ----------------------------------------

// Contents are undefined out of reset
regf_data_t mem [P_DEPTH];

// ----------------------------------------
// Write path
// ----------------------------------------

// Port b written last
// Same address on both ports leaves b's data
always_ff @(posedge i_clk_multipump)
begin
        if (i_wen)
        begin
                mem[i_addr_a] <= i_wr_data_a;
                mem[i_addr_b] <= i_wr_data_b;
        end
end

// ----------------------------------------
// Read path
// ----------------------------------------

// Read-first
// Old word sampled even when the same edge writes it
always_ff @(posedge i_clk_multipump)
begin
        o_rd_data_a <= mem[i_addr_a];
end

endmodule : regf_block_ram

`default_nettype wire

/* hw/regf_bram_wrapper.sv */
`timescale 1ns/1ps
`default_nettype none

// Four RAM banks run at twice the core rate
// Read phase: each bank serves its own read port
// Write phase: every bank takes both writes

module regf_bram_wrapper
        import regf_pkg::*;
        import pump_pkg::*;
#(
        parameter int P_DEPTH = REGF_DEPTH
)
(
        input  wire             i_clk_multipump,
        input  wire             i_reset,

        // Write peer
        input  wire             i_wen,
        input  regf_addr_t      i_wr_addr_a,
        input  regf_addr_t      i_wr_addr_b,
        input  regf_data_t      i_wr_data_a,
        input  regf_data_t      i_wr_data_b,

        // Read peer, one address per bank
        input  regf_addr_t      i_rd_addr_a,
        input  regf_addr_t      i_rd_addr_b,
        input  regf_addr_t      i_rd_addr_c,
        input  regf_addr_t      i_rd_addr_d,

        // Bank read registers, straight from the RAMs
        output regf_data_t      o_rd_data_a,
        output regf_data_t      o_rd_data_b,
        output regf_data_t      o_rd_data_c,
        output regf_data_t      o_rd_data_d,

        output pump_phase_t     o_phase
);

// ----------------------------------------
// Phase sequencer
// ----------------------------------------

pump_phase_t phase;

// Toggle every pump edge
// Reset lands on the read phase
always_ff @(posedge i_clk_multipump)
begin
        if (i_reset)
                phase <= READ_PH;
        else if (phase == READ_PH)
                phase <= WRITE_PH;
        else
                phase <= READ_PH;
end

assign o_phase = phase;

// ----------------------------------------
// Bank arbitration
// ----------------------------------------

regf_addr_t rd_addr   [PUMP_READ_BANKS];
regf_addr_t bank_addr_a [PUMP_READ_BANKS];
regf_addr_t bank_addr_b [PUMP_READ_BANKS];
regf_data_t bank_rd_data [PUMP_READ_BANKS];
logic       bank_wen;

// Read addresses gathered for indexing
assign rd_addr[0] = i_rd_addr_a;
assign rd_addr[1] = i_rd_addr_b;
assign rd_addr[2] = i_rd_addr_c;
assign rd_addr[3] = i_rd_addr_d;

always_comb
begin
        // Write enable only ever in the write phase
        bank_wen = (phase == WRITE_PH) ? i_wen : 1'b0;

        for (int i = 0; i < PUMP_READ_BANKS; i++)
        begin
                if (phase == READ_PH)
                begin
                        // Own read address, b port unused
                        bank_addr_a[i] = rd_addr[i];
                        bank_addr_b[i] = '0;
                end
                else
                begin
                        // Same write on all banks keeps copies identical
                        bank_addr_a[i] = i_wr_addr_a;
                        bank_addr_b[i] = i_wr_addr_b;
                end
        end
end

// ----------------------------------------
// RAM banks
// ----------------------------------------

for (genvar gi = 0; gi < PUMP_READ_BANKS; gi++)
begin : g_bank
        regf_block_ram #(
                .P_DEPTH        (P_DEPTH)
        ) u_ram (
                .i_clk_multipump(i_clk_multipump),
                .i_addr_a       (bank_addr_a[gi]),
                .i_addr_b       (bank_addr_b[gi]),
                .i_wen          (bank_wen),
                .i_wr_data_a    (i_wr_data_a),
                .i_wr_data_b    (i_wr_data_b),
                .o_rd_data_a    (bank_rd_data[gi])
        );
end

// Bank i feeds read port i
assign o_rd_data_a = bank_rd_data[0];
assign o_rd_data_b = bank_rd_data[1];
assign o_rd_data_c = bank_rd_data[2];
assign o_rd_data_d = bank_rd_data[3];

endmodule : regf_bram_wrapper

`default_nettype wire

/* hw/regf_core_port.sv */
`timescale 1ns/1ps
`default_nettype none

// Core-side boundary of the register file
// One request per core cycle, read words held for a whole core cycle

module regf_core_port
        import regf_pkg::*;
        import pump_pkg::*;
(
        input  wire             i_clk_multipump,
        input  wire             i_reset,

        // Sequencer phase from the wrapper
        input  pump_phase_t     i_phase,

        // Core request
        input  wire             i_wen,
        input  regf_addr_t      i_wr_addr_a,
        input  regf_addr_t      i_wr_addr_b,
        input  regf_data_t      i_wr_data_a,
        input  regf_data_t      i_wr_data_b,
        input  regf_addr_t      i_rd_addr_a,
        input  regf_addr_t      i_rd_addr_b,
        input  regf_addr_t      i_rd_addr_c,
        input  regf_addr_t      i_rd_addr_d,

        // Bank read words from the wrapper
        input  regf_data_t      i_bank_data_a,
        input  regf_data_t      i_bank_data_b,
        input  regf_data_t      i_bank_data_c,
        input  regf_data_t      i_bank_data_d,

        // Held request toward the wrapper
        output logic            o_wen,
        output regf_addr_t      o_wr_addr_a,
        output regf_addr_t      o_wr_addr_b,
        output regf_data_t      o_wr_data_a,
        output regf_data_t      o_wr_data_b,
        output regf_addr_t      o_rd_addr_a,
        output regf_addr_t      o_rd_addr_b,
        output regf_addr_t      o_rd_addr_c,
        output regf_addr_t      o_rd_addr_d,

        // Read results back to the core
        output regf_data_t      o_rd_data_a,
        output regf_data_t      o_rd_data_b,
        output regf_data_t      o_rd_data_c,
        output regf_data_t      o_rd_data_d
);

// ----------------------------------------
// Core cycle boundary
// ----------------------------------------

// Last pump cycle of a core cycle
logic core_edge;

// Banks hold a real read for the held request
logic req_valid;

assign core_edge = (i_phase == WRITE_PH);

// ----------------------------------------
// Request capture
// ----------------------------------------

// Control bits
always_ff @(posedge i_clk_multipump)
begin
        if (i_reset)
        begin
                o_wen     <= 1'b0;
                req_valid <= 1'b0;
        end
        else if (core_edge)
        begin
                o_wen     <= i_wen;
                req_valid <= 1'b1;
        end
end

// Payload, held across both pump phases
always_ff @(posedge i_clk_multipump)
begin
        if (core_edge)
        begin
                o_wr_addr_a <= i_wr_addr_a;
                o_wr_addr_b <= i_wr_addr_b;
                o_wr_data_a <= i_wr_data_a;
                o_wr_data_b <= i_wr_data_b;
                o_rd_addr_a <= i_rd_addr_a;
                o_rd_addr_b <= i_rd_addr_b;
                o_rd_addr_c <= i_rd_addr_c;
                o_rd_addr_d <= i_rd_addr_d;
        end
end

// ----------------------------------------
// Read result hold
// ----------------------------------------

// Bank words here were read one edge earlier, in the read phase
// First boundary after reset has nothing to return
always_ff @(posedge i_clk_multipump)
begin
        if (i_reset)
        begin
                o_rd_data_a <= '0;
                o_rd_data_b <= '0;
                o_rd_data_c <= '0;
                o_rd_data_d <= '0;
        end
        else if (core_edge && req_valid)
        begin
                o_rd_data_a <= i_bank_data_a;
                o_rd_data_b <= i_bank_data_b;
                o_rd_data_c <= i_bank_data_c;
                o_rd_data_d <= i_bank_data_d;
        end
end

endmodule : regf_core_port

`default_nettype wire

/* hw/regf_top.sv */
`timescale 1ns/1ps
`default_nettype none

// Register file, 2 write and 4 read ports
// Core side on the left, multipumped banks on the right

module regf_top
        import regf_pkg::*;
        import pump_pkg::*;
#(
        parameter int P_DEPTH = REGF_DEPTH
)
(
        input  wire             i_clk_multipump,
        input  wire             i_reset,

        input  wire             i_wen,
        input  regf_addr_t      i_wr_addr_a,
        input  regf_addr_t      i_wr_addr_b,
        input  regf_data_t      i_wr_data_a,
        input  regf_data_t      i_wr_data_b,
        input  regf_addr_t      i_rd_addr_a,
        input  regf_addr_t      i_rd_addr_b,
        input  regf_addr_t      i_rd_addr_c,
        input  regf_addr_t      i_rd_addr_d,

        output regf_data_t      o_rd_data_a,
        output regf_data_t      o_rd_data_b,
        output regf_data_t      o_rd_data_c,
        output regf_data_t      o_rd_data_d,

        // Core aligns its cycle to this
        output pump_phase_t     o_phase
);

// ----------------------------------------
// Held request, port to wrapper
// ----------------------------------------

logic           req_wen;
regf_addr_t     req_wr_addr_a;
regf_addr_t     req_wr_addr_b;
regf_data_t     req_wr_data_a;
regf_data_t     req_wr_data_b;
regf_addr_t     req_rd_addr_a;
regf_addr_t     req_rd_addr_b;
regf_addr_t     req_rd_addr_c;
regf_addr_t     req_rd_addr_d;

// Bank words, wrapper to port
regf_data_t     bank_data_a;
regf_data_t     bank_data_b;
regf_data_t     bank_data_c;
regf_data_t     bank_data_d;

pump_phase_t    phase;

assign o_phase = phase;

// ----------------------------------------
// Core port
// ----------------------------------------

regf_core_port u_core_port (
        .i_clk_multipump(i_clk_multipump),
        .i_reset        (i_reset),
        .i_phase        (phase),
        .i_wen          (i_wen),
        .i_wr_addr_a    (i_wr_addr_a),
        .i_wr_addr_b    (i_wr_addr_b),
        .i_wr_data_a    (i_wr_data_a),
        .i_wr_data_b    (i_wr_data_b),
        .i_rd_addr_a    (i_rd_addr_a),
        .i_rd_addr_b    (i_rd_addr_b),
        .i_rd_addr_c    (i_rd_addr_c),
        .i_rd_addr_d    (i_rd_addr_d),
        .i_bank_data_a  (bank_data_a),
        .i_bank_data_b  (bank_data_b),
        .i_bank_data_c  (bank_data_c),
        .i_bank_data_d  (bank_data_d),
        .o_wen          (req_wen),
        .o_wr_addr_a    (req_wr_addr_a),
        .o_wr_addr_b    (req_wr_addr_b),
        .o_wr_data_a    (req_wr_data_a),
        .o_wr_data_b    (req_wr_data_b),
        .o_rd_addr_a    (req_rd_addr_a),
        .o_rd_addr_b    (req_rd_addr_b),
        .o_rd_addr_c    (req_rd_addr_c),
        .o_rd_addr_d    (req_rd_addr_d),
        .o_rd_data_a    (o_rd_data_a),
        .o_rd_data_b    (o_rd_data_b),
        .o_rd_data_c    (o_rd_data_c),
        .o_rd_data_d    (o_rd_data_d)
);

// ----------------------------------------
// Multipumped banks
// ----------------------------------------

regf_bram_wrapper #(
        .P_DEPTH        (P_DEPTH)
) u_bram_wrapper (
        .i_clk_multipump(i_clk_multipump),
        .i_reset        (i_reset),
        .i_wen          (req_wen),
        .i_wr_addr_a    (req_wr_addr_a),
        .i_wr_addr_b    (req_wr_addr_b),
        .i_wr_data_a    (req_wr_data_a),
        .i_wr_data_b    (req_wr_data_b),
        .i_rd_addr_a    (req_rd_addr_a),
        .i_rd_addr_b    (req_rd_addr_b),
        .i_rd_addr_c    (req_rd_addr_c),
        .i_rd_addr_d    (req_rd_addr_d),
        .o_rd_data_a    (bank_data_a),
        .o_rd_data_b    (bank_data_b),
        .o_rd_data_c    (bank_data_c),
        .o_rd_data_d    (bank_data_d),
        .o_phase        (phase)
);

endmodule : regf_top

`default_nettype wire

/* tests/regf_sva.sv */
`timescale 1ns/1ps
`default_nettype none

// Phase and write enable rules of the multipump wrapper

module regf_sva
        import pump_pkg::*;
(
        input  wire             i_clk_multipump,
        input  wire             i_reset,
        input  pump_phase_t     i_phase,
        input  wire             i_wen,
        input  wire             i_bank_wen
);

// ----------------------------------------
// Phase sequencer
// ----------------------------------------

// Toggle on every edge once reset is gone
phase_toggles: assert property (@(posedge i_clk_multipump) disable iff (i_reset)
        !i_reset |=> (i_phase != $past(i_phase)))
        else $error("phase held its value across a pump edge");

// Reset parks the sequencer in the read phase
phase_after_reset: assert property (@(posedge i_clk_multipump)
        i_reset |=> (i_phase == READ_PH))
        else $error("phase not READ_PH on the cycle after reset");

// ----------------------------------------
// Bank writes
// ----------------------------------------

// Banks write with the enable held since the read phase
wen_held_to_write: assert property (@(posedge i_clk_multipump) disable iff (i_reset)
        (i_phase == WRITE_PH) |-> (i_bank_wen == $past(i_wen)))
        else $error("bank write enable differs from the enable held in the read phase");

endmodule : regf_sva

bind regf_bram_wrapper regf_sva u_sva (
        .i_clk_multipump(i_clk_multipump),
        .i_reset        (i_reset),
        .i_phase        (phase),
        .i_wen          (i_wen),
        .i_bank_wen     (bank_wen)
);

`default_nettype wire

/* tests/regf_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module regf_tb
        import regf_pkg::*;
        import pump_pkg::*;
();

localparam int          CLK_HALF_NS  = 10;
localparam int          RESET_CYCLES = 8;
localparam int          MAX_ENTRIES  = 32;
localparam logic [31:0] LFSR_SEED    = 32'h23c3;
// Taps 32 22 2 1, right-shifting form
localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;

logic           clk_multipump;
logic           reset;
logic           wen;
regf_addr_t     wr_addr_a;
regf_addr_t     wr_addr_b;
regf_data_t     wr_data_a;
regf_data_t     wr_data_b;
regf_addr_t     rd_addr_a;
regf_addr_t     rd_addr_b;
regf_addr_t     rd_addr_c;
regf_addr_t     rd_addr_d;
regf_data_t     rd_data_a;
regf_data_t     rd_data_b;
regf_data_t     rd_data_c;
regf_data_t     rd_data_d;
pump_phase_t    phase;

// Stimulus table, one entry per core cycle
bit             tbl_wen  [$];
regf_addr_t     tbl_wr_a [$];
regf_addr_t     tbl_wr_b [$];
regf_addr_t     tbl_rd_a [$];
regf_addr_t     tbl_rd_b [$];
regf_addr_t     tbl_rd_c [$];
regf_addr_t     tbl_rd_d [$];
bit             tbl_rnd  [$];

// Reference model and predicted read words
regf_data_t     model_mem   [REGF_DEPTH];
bit             model_known [REGF_DEPTH];
regf_data_t     exp_rd      [MAX_ENTRIES][PUMP_READ_BANKS];
bit             exp_known   [MAX_ENTRIES][PUMP_READ_BANKS];

logic [31:0]    lfsr_state;
int             data_errors;
int             phase_errors;
int             n_entries;
bit             table_ready;

regf_top #(
        .P_DEPTH        (REGF_DEPTH)
) dut0 (
        .i_clk_multipump(clk_multipump),
        .i_reset        (reset),
        .i_wen          (wen),
        .i_wr_addr_a    (wr_addr_a),
        .i_wr_addr_b    (wr_addr_b),
        .i_wr_data_a    (wr_data_a),
        .i_wr_data_b    (wr_data_b),
        .i_rd_addr_a    (rd_addr_a),
        .i_rd_addr_b    (rd_addr_b),
        .i_rd_addr_c    (rd_addr_c),
        .i_rd_addr_d    (rd_addr_d),
        .o_rd_data_a    (rd_data_a),
        .o_rd_data_b    (rd_data_b),
        .o_rd_data_c    (rd_data_c),
        .o_rd_data_d    (rd_data_d),
        .o_phase        (phase)
);

// Pump clock, 20 ns period
always #(CLK_HALF_NS) clk_multipump = ~clk_multipump;

// ----------------------------------------
// Data sources
// ----------------------------------------

function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0])
                return (s >> 1) ^ LFSR_TAPS;
        else
                return s >> 1;
endfunction

// One LFSR step per data bit
task automatic random_word(output regf_data_t word);
        word = '0;
        for (int b = 0; b < REGF_DATA_W; b++)
        begin
                lfsr_state = lfsr_next(lfsr_state);
                word[b] = lfsr_state[0];
        end
endtask

// Fixed data, tagged with port, entry and address
function automatic regf_data_t pattern_word(input int entry, input int port,
                                            input regf_addr_t addr);
        return {4'hC + 4'(port), 12'h0, 8'(entry), 2'b00, addr};
endfunction

// ----------------------------------------
// Stimulus table
// ----------------------------------------

task automatic add_entry(input bit wen_v, input int wa, input int wb, input int ra,
                         input int rb, input int rc, input int rd, input bit rnd);
        tbl_wen.push_back(wen_v);
        tbl_wr_a.push_back(regf_addr_t'(wa));
        tbl_wr_b.push_back(regf_addr_t'(wb));
        tbl_rd_a.push_back(regf_addr_t'(ra));
        tbl_rd_b.push_back(regf_addr_t'(rb));
        tbl_rd_c.push_back(regf_addr_t'(rc));
        tbl_rd_d.push_back(regf_addr_t'(rd));
        tbl_rnd.push_back(rnd);
endtask

task automatic build_table();
        // Fill 1 and 2, reads of empty registers go unchecked
        add_entry(1'b1,  1,  2,  1,  2,  3,  4, 1'b0);
        // All four ports see the first writes
        add_entry(1'b1,  3,  4,  1,  2,  1,  2, 1'b1);
        // Read-first on 1 and 3
        add_entry(1'b1,  1,  3,  1,  3,  2,  4, 1'b1);
        // New values of 1 and 3, write to 2 and 4 dropped
        add_entry(1'b0,  2,  4,  1,  3,  1,  3, 1'b1);
        // 2 and 4 unchanged; both ports on 7
        add_entry(1'b1,  7,  7,  2,  4,  2,  4, 1'b0);
        // Port b data in 7
        add_entry(1'b0,  7,  7,  7,  7,  7,  7, 1'b1);
        add_entry(1'b1, 10, 11,  1,  2,  3,  4, 1'b1);
        // Top and bottom of the array
        add_entry(1'b1, 63,  0, 10, 11,  7,  1, 1'b1);
        add_entry(1'b1, 20, 20, 63,  0, 63,  0, 1'b1);
        add_entry(1'b0, 20, 21, 20, 10, 11,  4, 1'b1);
        add_entry(1'b1,  4,  2,  4,  2, 63, 20, 1'b0);
        add_entry(1'b1, 33, 34,  4,  2,  0,  7, 1'b1);
        add_entry(1'b0,  0,  0, 33, 34,  1,  3, 1'b1);
        add_entry(1'b1,  5,  5, 63, 10, 33, 34, 1'b1);
endtask

// ----------------------------------------
// Driving and prediction
// ----------------------------------------

task automatic drive_entry(input int k);
        regf_addr_t rd [PUMP_READ_BANKS];
        regf_data_t da;
        regf_data_t db;
        rd[0] = tbl_rd_a[k];
        rd[1] = tbl_rd_b[k];
        rd[2] = tbl_rd_c[k];
        rd[3] = tbl_rd_d[k];
        if (tbl_rnd[k])
        begin
                random_word(da);
                random_word(db);
        end
        else
        begin
                da = pattern_word(k, 0, tbl_wr_a[k]);
                db = pattern_word(k, 1, tbl_wr_b[k]);
        end
        wen       = tbl_wen[k];
        wr_addr_a = tbl_wr_a[k];
        wr_addr_b = tbl_wr_b[k];
        wr_data_a = da;
        wr_data_b = db;
        rd_addr_a = rd[0];
        rd_addr_b = rd[1];
        rd_addr_c = rd[2];
        rd_addr_d = rd[3];
        // Reads see the state before this entry's writes
        for (int p = 0; p < PUMP_READ_BANKS; p++)
        begin
                exp_rd[k][p]    = model_mem[rd[p]];
                exp_known[k][p] = model_known[rd[p]];
        end
        // a first, b second, so b wins a collision
        if (tbl_wen[k])
        begin
                model_mem[tbl_wr_a[k]]   = da;
                model_known[tbl_wr_a[k]] = 1'b1;
                model_mem[tbl_wr_b[k]]   = db;
                model_known[tbl_wr_b[k]] = 1'b1;
        end
endtask

task automatic drive_idle();
        wen       = 1'b0;
        wr_addr_a = '0;
        wr_addr_b = '0;
        wr_data_a = '0;
        wr_data_b = '0;
        rd_addr_a = '0;
        rd_addr_b = '0;
        rd_addr_c = '0;
        rd_addr_d = '0;
endtask

// ----------------------------------------
// Compare tasks
// ----------------------------------------

task automatic check_data(input string what, input regf_data_t got, input regf_data_t exp);
        if (got !== exp)
        begin
                $display("FAIL at %0d ns: %s read %h, expected %h", $time, what, got, exp);
                data_errors++;
        end
endtask

task automatic check_phase(input string what, input pump_phase_t exp);
        if (phase !== exp)
        begin
                $display("FAIL at %0d ns: phase %s, got %s, expected %s",
                         $time, what, phase.name(), exp.name());
                phase_errors++;
        end
endtask

task automatic check_outputs(input int k);
        regf_data_t got [PUMP_READ_BANKS];
        got[0] = rd_data_a;
        got[1] = rd_data_b;
        got[2] = rd_data_c;
        got[3] = rd_data_d;
        for (int p = 0; p < PUMP_READ_BANKS; p++)
        begin
                if (exp_known[k][p])
                        check_data($sformatf("entry %0d port %0d", k, p), got[p], exp_rd[k][p]);
        end
endtask

task automatic check_cleared(input string when);
        check_data({"port a ", when}, rd_data_a, '0);
        check_data({"port b ", when}, rd_data_b, '0);
        check_data({"port c ", when}, rd_data_c, '0);
        check_data({"port d ", when}, rd_data_d, '0);
endtask

// ----------------------------------------
// Main sequence
// ----------------------------------------

initial
begin
        clk_multipump = 1'b0;
        reset         = 1'b1;
        drive_idle();
        lfsr_state    = LFSR_SEED;
        data_errors   = 0;
        phase_errors  = 0;
        for (int r = 0; r < REGF_DEPTH; r++)
        begin
                model_mem[r]   = '0;
                model_known[r] = 1'b0;
        end
        build_table();
        n_entries   = tbl_wen.size();
        table_ready = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk_multipump);
        #1;
        reset = 1'b0;
        check_phase("after reset", READ_PH);
        check_cleared("after reset");

        // First edge out of reset opens a write phase
        @(posedge clk_multipump);
        #1;
        check_phase("first write phase", WRITE_PH);

        // One extra core cycle flushes the last entry
        for (int k = 0; k <= n_entries; k++)
        begin
                if (k < n_entries)
                        drive_entry(k);
                else
                        drive_idle();
                // Capture edge, previous entry lands on the outputs
                @(posedge clk_multipump);
                #1;
                check_phase("after capture", READ_PH);
                if (k == 0)
                        check_cleared("before first latch");
                else
                        check_outputs(k - 1);
                // Outputs must hold through the read phase
                @(posedge clk_multipump);
                #1;
                check_phase("mid core cycle", WRITE_PH);
                if (k == 0)
                        check_cleared("before first latch");
                else
                        check_outputs(k - 1);
        end

        $display("Done: %0d data errors, %0d phase errors over %0d entries",
                 data_errors, phase_errors, n_entries);
        if (data_errors == 0 && phase_errors == 0)
        begin
                $display("=== PASS ===");
        end
        else
        begin
                $display("=== FAIL ===");
        end
        $finish;
end

// Reset, table entries and flush at 40 ns per core cycle, plus margin
initial
begin : watchdog
        int limit_ns;
        wait (table_ready);
        limit_ns = RESET_CYCLES * 2 * CLK_HALF_NS + (n_entries + 2) * 4 * CLK_HALF_NS + 400;
        #(limit_ns);
        $display("Timeout: the run did not finish within %0d ns", limit_ns);
        $display("=== FAIL ===");
        $finish;
end

endmodule : regf_tb

`default_nettype wire

/* src.f */
hw/regf_pkg.sv
hw/pump_pkg.sv
hw/regf_block_ram.sv
hw/regf_bram_wrapper.sv
hw/regf_core_port.sv
hw/regf_top.sv
tests/regf_sva.sv
tests/regf_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the register file testbench with Verilator
set -e

cd "$(dirname "$0")"

TOP=regf_tb
OBJ_DIR=obj_dir
LOG=sim.log

rm -rf "$OBJ_DIR" "$LOG"

verilator --binary --timing --assert -Wno-fatal \
        -f src.f --top-module "$TOP" --Mdir "$OBJ_DIR" -o "$TOP"

# A failed assertion may end the run with an error status
"./$OBJ_DIR/$TOP" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qx "=== PASS ===" "$LOG"; then
        echo "run_sim: simulation passed"
        exit 0
else
        echo "run_sim: simulation failed, see $LOG"
        exit 1
fi
